/* tb.f */
verilog/chess_bus_pkg.sv
verilog/chess_move_pkg.sv
verilog/host_regs.sv
verilog/move_ram.sv
verilog/move_collector.sv
verilog/move_list_ctrl.sv
bench/move_list_properties.sv
bench/tb_move_list.sv

/* Bender.yml */
package:
  name: move_list_ctrl

sources:
  # design, packages first
  - files:
      - verilog/chess_bus_pkg.sv
      - verilog/chess_move_pkg.sv
      - verilog/host_regs.sv
      - verilog/move_ram.sv
      - verilog/move_collector.sv
      - verilog/move_list_ctrl.sv
  # testbench
  - target: test
    files:
      - bench/move_list_properties.sv
      - bench/tb_move_list.sv

/* bench/tb_move_list.sv */
`default_nettype none

module tb_move_list;
	timeunit 1ns;
	timeprecision 100ps;
	import chess_bus_pkg::*;
	import chess_move_pkg::*;

	localparam int ADDR_WIDTH = 13;
	localparam int TIMEOUT    = 200;   // polls or cycles per wait

	logic                     clk = 1'b0;
	logic                     arst_n;
	logic [ADDR_WIDTH-1:0]    address;
	logic                     read, write;
	logic [DATA_WIDTH-1:0]    writedata, readdata;
	logic                     lmg_reset, lmg_lcas, lmg_rcas, lmg_rden;
	board_t                   lmg_board;
	logic [7:0]               lmg_enp;
	logic                     lmg_done;
	logic [LMG_WORD_BITS-1:0] lmg_fifo_out;
	logic                     lmg_fifo_empty;

	logic [LMG_WORD_BITS-1:0] fifo_q [$];       // words the lmg model still holds
	logic [LMG_WORD_BITS-1:0] held;             // popped word on its way out
	logic                     rden_seen  = 1'b0;
	int                       done_delay = 0;
	logic [15:0]              lfsr       = 16'd56;
	logic [DATA_WIDTH-1:0]    exp_moves [$];    // reference list in stored form

	move_list_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) dut (
		.clk, .arst_n, .address, .read, .write, .writedata, .readdata,
		.lmg_reset, .lmg_board, .lmg_lcas, .lmg_rcas, .lmg_enp, .lmg_rden,
		.lmg_done, .lmg_fifo_out, .lmg_fifo_empty
	);

	always #2 clk = ~clk;  // 4 ns period

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
				$time, what, got, exp));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [LMG_WORD_BITS-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[15];
			lfsr = lfsr_next(lfsr);  // one step per bit
		end
	endtask

	// both bus tasks start and end on a falling edge
	task automatic bus_write(input int addr, input logic [DATA_WIDTH-1:0] data);
		address   = ADDR_WIDTH'(addr);
		writedata = data;
		write     = 1'b1;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic bus_read(input int addr, output logic [DATA_WIDTH-1:0] data);
		address = ADDR_WIDTH'(addr);
		read    = 1'b1;
		@(negedge clk);
		read = 1'b0;
		data = readdata;  // answer sits on the bus one clock after the strobe
	endtask

	// ======================================================================
	// lmg model
	// ======================================================================

	always @(negedge clk) begin
		if (lmg_reset) begin
			lmg_done   = 1'b0;     // new run, old done goes away
			done_delay = 3;
		end else if (done_delay > 0) begin
			done_delay--;
			if (done_delay == 0)
				lmg_done = 1'b1;
		end
		if (rden_seen)
			lmg_fifo_out = held;   // second clock after the pop
		rden_seen = 1'b0;
		if (lmg_rden) begin
			if (fifo_q.size() == 0)
				fail_now("the controller popped the lmg fifo while it was empty");
			held      = fifo_q.pop_front();
			rden_seen = 1'b1;
		end
		lmg_fifo_empty = (fifo_q.size() == 0);
	end

	always @(negedge clk) begin
		if (dut.u_props.fail_count != 0)
			fail_now("a bound assertion on move_list_ctrl fired");
	end

	// ======================================================================
	// list handling
	// ======================================================================

	// blank picks a word with all entries invalid, -1 for none
	task automatic start_list(input ctrl_word_t c, input int words, input int blank);
		logic [LMG_WORD_BITS-1:0] w;
		logic [ENTRY_BITS-1:0]    e;
		c.start = 1'b0;
		c.done  = 1'b0;
		bus_write(REG_CTRL, c);  // start low first so the next write is an edge
		exp_moves.delete();
		for (int i = 0; i < words; i++) begin
			random_bits(LMG_WORD_BITS, w);
			for (int k = 0; k < ENTRIES_PER_WORD; k++) begin
				if (i == blank)
					w[ENTRY_BITS*k + ENTRY_BITS-1] = 1'b1;
				e = w[ENTRY_BITS*k +: ENTRY_BITS];
				// stored form swaps file and rank of each square
				if (!e[18])
					exp_moves.push_back({14'b0, e[17:12], e[8:6], e[11:9], e[2:0], e[5:3]});
			end
			fifo_q.push_back(w);
		end
		c.start = 1'b1;
		bus_write(REG_CTRL, c);
	endtask

	task automatic wait_lmg_reset();
		int n = 0;
		while (!lmg_reset) begin
			if (++n > TIMEOUT)
				fail_now("timeout waiting for the lmg_reset pulse after start");
			@(negedge clk);
		end
		@(negedge clk);
		check(lmg_reset, 0, "lmg_reset lasts one cycle");
	endtask

	task automatic wait_list_done();
		logic [DATA_WIDTH-1:0] w;
		ctrl_word_t            c;
		int                    n = 0;
		c = '0;
		while (!c.done) begin
			if (++n > TIMEOUT)
				fail_now("timeout waiting for the done bit in the control word");
			bus_read(REG_CTRL, w);
			c = w;
		end
	endtask

	task automatic check_list();
		logic [DATA_WIDTH-1:0] w;
		check(fifo_q.size(), 0, "lmg fifo drained");
		bus_read(ADDR_COUNT, w);
		check(w, exp_moves.size(), "move count at word 16");
		foreach (exp_moves[i]) begin
			bus_read(ADDR_FIRST_MOVE + i, w);
			check(w, exp_moves[i], $sformatf("move %0d", i));
		end
		bus_read(ADDR_FIRST_MOVE + exp_moves.size(), w);
		check(w, 0, "zero terminator after the last move");
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================

	function automatic logic [DATA_WIDTH-1:0] reg_pattern(input int i);
		logic [DATA_WIDTH-1:0] v;
		v = 32'h1357_9bdf ^ (i * 32'h0102_0408);
		if (i == REG_CTRL)
			v[1:0] = 2'b00;  // start and done stay low
		return v;
	endfunction

	task automatic test_reg_window();
		logic [DATA_WIDTH-1:0] w;
		for (int i = 0; i < REG_WORDS; i++)
			bus_write(i, reg_pattern(i));
		for (int i = 0; i < REG_WORDS; i++) begin
			bus_read(i, w);
			check(w, reg_pattern(i), $sformatf("register %0d readback", i));
		end
		@(negedge clk);
		check(readdata, 0, "readdata idle after a window read");
	endtask

	task automatic test_ram_rw();
		int addrs [3] = '{ADDR_COUNT, 300, 2**ADDR_WIDTH - 1};
		logic [DATA_WIDTH-1:0] w;
		foreach (addrs[i])
			bus_write(addrs[i], 32'hc0de_0000 | addrs[i]);
		foreach (addrs[i]) begin
			bus_read(addrs[i], w);
			check(w, 32'hc0de_0000 | addrs[i], $sformatf("ram word %0d readback", addrs[i]));
		end
		@(negedge clk);
		check(readdata, 0, "readdata idle after a ram read");
	endtask

	task automatic test_start_outputs();
		logic [LMG_WORD_BITS-1:0] r;
		logic [255:0]             exp_board;
		logic [7:0]               exp_enp;
		ctrl_word_t               c;
		for (int i = REG_BOARD_LO; i <= REG_BOARD_HI; i++) begin
			random_bits(DATA_WIDTH, r);
			bus_write(i, r[DATA_WIDTH-1:0]);
			exp_board[DATA_WIDTH*(i-REG_BOARD_LO) +: DATA_WIDTH] = r[DATA_WIDTH-1:0];
		end
		c          = '0;
		c.enp_file = 3'd5;
		c.lcas     = 1'b1;
		for (int i = 0; i < 8; i++)
			exp_enp[i] = (i == 5);
		start_list(c, 1, 0);  // single empty word, list stays empty
		check(lmg_board, exp_board, "board image to the lmg");
		check(lmg_lcas, 1, "lmg_lcas");
		check(lmg_rcas, 0, "lmg_rcas");
		check(lmg_enp, exp_enp, "lmg_enp one-hot");
		wait_lmg_reset();
		wait_list_done();
		check_list();
	endtask

	task automatic test_lists();
		logic [DATA_WIDTH-1:0] w;
		ctrl_word_t            c;
		c          = '0;
		c.rcas     = 1'b1;
		c.enp_file = 3'd2;
		start_list(c, 1, -1);  // one word, random validity
		wait_list_done();
		check_list();
		start_list(c, 3, 1);   // middle word carries nothing
		wait_list_done();
		check_list();
		c.done = 1'b1;           // written high, only start low can clear it
		bus_write(REG_CTRL, c);  // start low again
		bus_read(REG_CTRL, w);
		check(w[1], 0, "done clears with start");
		start_list(c, 2, -1);
		wait_list_done();
		check_list();
	endtask

	initial begin
		arst_n         = 1'b0;
		address        = '0;
		read           = 1'b0;
		write          = 1'b0;
		writedata      = '0;
		lmg_done       = 1'b0;
		lmg_fifo_out   = '0;
		lmg_fifo_empty = 1'b1;
		held           = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_reg_window();
		test_ram_rw();
		test_start_outputs();
		test_lists();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/move_list_properties.sv */
`default_nettype none

module move_list_properties #(
	parameter int ADDR_WIDTH = 13
) (
	input wire logic                                 clk,
	input wire logic                                 arst_n,
	input wire logic [ADDR_WIDTH-1:0]                address,
	input wire logic                                 write,
	input wire logic [chess_bus_pkg::DATA_WIDTH-1:0] writedata,
	input wire logic                                 lmg_reset,
	input wire logic                                 lmg_rden,
	input wire chess_bus_pkg::ctrl_word_t            ctrl
);
	timeunit 1ns;
	timeprecision 100ps;
	import chess_bus_pkg::*;

	int         fail_count = 0;  // polled by the testbench
	ctrl_word_t wr_ctrl;         // bus write data seen as a control word
	logic       start_wr;        // write that takes start from 0 to 1

	assign wr_ctrl  = writedata;
	assign start_wr = write && address == ADDR_WIDTH'(REG_CTRL) && wr_ctrl.start && !ctrl.start;

	// ======================================================================
	// lmg handshake
	// ======================================================================

	a_rden_single: assert property (@(posedge clk) disable iff (!arst_n)
		lmg_rden |=> !lmg_rden)
		else begin
			fail_count++;
			$error("lmg_rden high for two cycles in a row");
		end

	a_reset_follows_start: assert property (@(posedge clk) disable iff (!arst_n)
		start_wr |-> ##2 lmg_reset)
		else begin
			fail_count++;
			$error("no lmg_reset two clocks after a start write");
		end

	a_reset_only_after_start: assert property (@(posedge clk) disable iff (!arst_n)
		lmg_reset |-> $past(start_wr, 2))
		else begin
			fail_count++;
			$error("lmg_reset without a start write two clocks before");
		end

	// done lives only under start
	a_done_needs_start: assert property (@(posedge clk) disable iff (!arst_n)
		!ctrl.start |-> !ctrl.done)
		else begin
			fail_count++;
			$error("done bit set while start is low");
		end

endmodule

bind move_list_ctrl move_list_properties #(.ADDR_WIDTH(ADDR_WIDTH)) u_props (
	.clk(clk), .arst_n(arst_n), .address(address), .write(write), .writedata(writedata),
	.lmg_reset(lmg_reset), .lmg_rden(lmg_rden), .ctrl(ctrl)
);

`default_nettype wire

/* verilog/move_list_ctrl.sv */
`default_nettype none

module move_list_ctrl #(
	parameter int ADDR_WIDTH = 13
) (
	input  wire logic                                    clk,
	input  wire logic                                    arst_n,
	// slave bus
	input  wire logic [ADDR_WIDTH-1:0]                   address,
	input  wire logic                                    read,
	input  wire logic                                    write,
	input  wire logic [chess_bus_pkg::DATA_WIDTH-1:0]    writedata,
	output logic      [chess_bus_pkg::DATA_WIDTH-1:0]    readdata,
	// legal move generator
	output logic                                         lmg_reset,
	output chess_bus_pkg::board_t                        lmg_board,
	output logic                                         lmg_lcas,
	output logic                                         lmg_rcas,
	output logic      [7:0]                              lmg_enp,
	output logic                                         lmg_rden,
	input  wire logic                                    lmg_done,
	input  wire logic [chess_move_pkg::LMG_WORD_BITS-1:0] lmg_fifo_out,
	input  wire logic                                    lmg_fifo_empty
);
	import chess_bus_pkg::*;
	import chess_move_pkg::*;

	ctrl_word_t            ctrl;
	logic                  start_pulse;
	logic                  list_done;
	logic                  ram_we;
	logic [ADDR_WIDTH-1:0] ram_waddr;
	logic [DATA_WIDTH-1:0] ram_wdata;
	logic [ADDR_WIDTH-1:0] ram_raddr;
	logic [DATA_WIDTH-1:0] ram_rdata;
	ram_wr_t               coll_wr;

	// ======================================================================
	// peers: register window, move ram, collector
	// ======================================================================

	host_regs #(.ADDR_WIDTH(ADDR_WIDTH)) u_regs (
		.clk, .arst_n,
		.address, .read, .write, .writedata, .readdata,
		.ctrl, .board(lmg_board), .start_pulse, .list_done,
		.ram_we, .ram_waddr, .ram_wdata, .ram_raddr, .ram_rdata
	);

	move_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
		.clk,
		.host_we(ram_we), .host_waddr(ram_waddr), .host_wdata(ram_wdata),
		.coll_wr,
		.raddr(ram_raddr), .rdata(ram_rdata)
	);

	move_collector u_coll (
		.clk, .arst_n, .start_pulse,
		.lmg_reset, .lmg_rden, .lmg_done, .lmg_fifo_empty, .lmg_fifo_out,
		.coll_wr, .list_done
	);

	// flags to the lmg straight from the control word
	assign lmg_lcas = ctrl.lcas;
	assign lmg_rcas = ctrl.rcas;
	assign lmg_enp  = 8'(1) << ctrl.enp_file;  // one-hot en-passant file

endmodule

`default_nettype wire

/* verilog/move_collector.sv */
`default_nettype none

module move_collector (
	input  wire logic                                    clk,
	input  wire logic                                    arst_n,
	input  wire logic                                    start_pulse,
	// lmg side
	output logic                                         lmg_reset,
	output logic                                         lmg_rden,
	input  wire logic                                    lmg_done,
	input  wire logic                                    lmg_fifo_empty,
	input  wire logic [chess_move_pkg::LMG_WORD_BITS-1:0] lmg_fifo_out,
	// move ram and host side
	output chess_move_pkg::ram_wr_t                      coll_wr,
	output logic                                         list_done
);
	import chess_bus_pkg::*;
	import chess_move_pkg::*;

	collect_state_e            state;
	logic [ENTRY_IDX_BITS-1:0] ent_idx;    // entry being scanned in the current word
	logic [COUNT_BITS-1:0]     count;      // moves written so far, also the next slot
	logic                      done_q;     // lmg_done last clock, for the edge
	lmg_word_t                 fifo_word;
	lmg_entry_t                cur;        // entry under the scan pointer
	move_t                     mv;         // cur in stored form

	// ======================================================================
	// entry select and reorder
	// ======================================================================

	assign fifo_word = lmg_word_t'(lmg_fifo_out);
	assign cur       = fifo_word.entry[ent_idx];

	always_comb begin
		mv = '{
			tag:       cur.tag,
			from_rank: cur.from_rank,   // rank and file swap places
			from_file: cur.from_file,
			to_rank:   cur.to_rank,
			to_file:   cur.to_file
		};
	end

	// ======================================================================
	// state machine
	// ======================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			ent_idx   <= '0;
			count     <= '0;
			lmg_reset <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			lmg_reset <= start_pulse;   // one pulse per start
			done_q    <= lmg_done;
			if (start_pulse) begin
				// restart from wherever we are
				state <= WAIT_DONE;
				count <= '0;
			end else begin
				case (state)
					WAIT_DONE: begin
						// only a fresh done counts, an old one may linger
						if (lmg_done && !done_q)
							state <= POP;
					end
					POP: state <= PREFETCH;          // rden out this cycle
					PREFETCH: begin
						state   <= SCAN;             // fifo data lands next clock
						ent_idx <= '0;
					end
					SCAN: begin
						if (!cur.invalid)
							count <= count + 1'b1;
						ent_idx <= ent_idx + 1'b1;
						if (ent_idx == ENTRY_IDX_BITS'(ENTRIES_PER_WORD - 1)) begin
							if (lmg_fifo_empty)
								state <= WRITE_COUNT;  // that was the last word
							else
								state <= POP;
						end
					end
					WRITE_COUNT: state <= WRITE_TERM;
					WRITE_TERM:  state <= FINISHED;
					default: ;                       // IDLE and FINISHED wait for start
				endcase
			end
		end
	end

	// ======================================================================
	// outputs, decoded from state
	// ======================================================================

	assign lmg_rden  = (state == POP);
	assign list_done = (state == WRITE_TERM);  // host sets done on the next edge

	always_comb begin
		coll_wr = '0;
		case (state)
			SCAN: begin
				coll_wr.en    = !cur.invalid;     // skip empty slots
				coll_wr.index = count;
				coll_wr.data  = DATA_WIDTH'(mv);
			end
			WRITE_COUNT: begin
				coll_wr.en       = 1'b1;
				coll_wr.is_count = 1'b1;
				coll_wr.data     = DATA_WIDTH'(count);
			end
			WRITE_TERM: begin
				coll_wr.en    = 1'b1;             // zero word right after the last move
				coll_wr.index = count;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/move_ram.sv */
`default_nettype none

module move_ram #(
	parameter int ADDR_WIDTH = 13
) (
	input  wire logic                                 clk,
	// host write port
	input  wire logic                                 host_we,
	input  wire logic [ADDR_WIDTH-1:0]                host_waddr,
	input  wire logic [chess_bus_pkg::DATA_WIDTH-1:0] host_wdata,
	// collector write request
	input  wire chess_move_pkg::ram_wr_t              coll_wr,
	// read port
	input  wire logic [ADDR_WIDTH-1:0]                raddr,
	output logic      [chess_bus_pkg::DATA_WIDTH-1:0] rdata
);
	import chess_bus_pkg::*;
	import chess_move_pkg::*;

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];
	logic                  we;
	logic [ADDR_WIDTH-1:0] waddr;
	logic [DATA_WIDTH-1:0] wdata;

	// ======================================================================
	// write arbiter, collector always wins
	// ======================================================================

	always_comb begin
		we    = host_we;
		waddr = host_waddr;
		wdata = host_wdata;
		if (coll_wr.en) begin
			we    = 1'b1;           // host write this cycle is lost
			wdata = coll_wr.data;
			if (coll_wr.is_count)
				waddr = ADDR_WIDTH'(ADDR_COUNT);
			else
				waddr = ADDR_WIDTH'(ADDR_FIRST_MOVE) + ADDR_WIDTH'(coll_wr.index);
		end
	end

	// simple dual port, registered read
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];    // old data on a same-address collision
	end

endmodule

`default_nettype wire

/* verilog/host_regs.sv */
`default_nettype none

module host_regs #(
	parameter int ADDR_WIDTH = 13
) (
	input  wire logic                                 clk,
	input  wire logic                                 arst_n,
	// slave bus
	input  wire logic [ADDR_WIDTH-1:0]                address,
	input  wire logic                                 read,
	input  wire logic                                 write,
	input  wire logic [chess_bus_pkg::DATA_WIDTH-1:0] writedata,
	output logic      [chess_bus_pkg::DATA_WIDTH-1:0] readdata,
	// decoded register contents
	output chess_bus_pkg::ctrl_word_t                 ctrl,
	output chess_bus_pkg::board_t                     board,
	output logic                                      start_pulse,
	input  wire logic                                 list_done,
	// move ram side
	output logic                                      ram_we,
	output logic      [ADDR_WIDTH-1:0]                ram_waddr,
	output logic      [chess_bus_pkg::DATA_WIDTH-1:0] ram_wdata,
	output logic      [ADDR_WIDTH-1:0]                ram_raddr,
	input  wire logic [chess_bus_pkg::DATA_WIDTH-1:0] ram_rdata
);
	import chess_bus_pkg::*;

	logic [DATA_WIDTH-1:0]   regs [REG_WORDS];  // the register window
	logic                    in_window;         // address hits 0..15
	logic [REG_IDX_BITS-1:0] reg_idx;
	ctrl_word_t              ctrl_next;
	logic                    start_q;           // start as seen last clock
	logic                    rd_win_q;          // a window read is answered this cycle
	logic                    rd_ram_q;          // a ram read is answered this cycle
	logic [DATA_WIDTH-1:0]   rd_word_q;

	// ======================================================================
	// address decode
	// ======================================================================

	assign in_window = (address >> REG_IDX_BITS) == '0;
	assign reg_idx   = address[REG_IDX_BITS-1:0];

	// anything outside the window goes straight to the ram
	assign ram_we    = write & ~in_window;
	assign ram_waddr = address;
	assign ram_wdata = writedata;
	assign ram_raddr = address;  // ram reads every cycle, result used only after a strobe

	// ======================================================================
	// control word, done bit and start edge
	// ======================================================================

	assign ctrl = ctrl_word_t'(regs[REG_CTRL]);

	always_comb begin
		ctrl_next = ctrl;
		if (write && in_window && reg_idx == REG_IDX_BITS'(REG_CTRL))
			ctrl_next = ctrl_word_t'(writedata);
		if (list_done)
			ctrl_next.done = 1'b1;       // collector finished the list
		if (!ctrl_next.start)
			ctrl_next.done = 1'b0;       // no done without start
	end

	assign start_pulse = ctrl.start & ~start_q;  // high in the clock after the write

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_WORDS; i++)
				regs[i] <= '0;
			start_q  <= 1'b0;
			rd_win_q <= 1'b0;
			rd_ram_q <= 1'b0;
		end else begin
			for (int i = 0; i < REG_WORDS; i++) begin
				if (i != REG_CTRL && write && in_window && reg_idx == REG_IDX_BITS'(i))
					regs[i] <= writedata;
			end
			regs[REG_CTRL] <= ctrl_next;
			start_q        <= ctrl.start;
			rd_win_q       <= read & in_window;
			rd_ram_q       <= read & ~in_window;
		end
	end

	// ======================================================================
	// read path, one clock after the strobe for both regions
	// ======================================================================

	always_ff @(posedge clk) begin
		if (read && in_window)
			rd_word_q <= regs[reg_idx];
	end

	assign readdata = rd_win_q ? rd_word_q : (rd_ram_q ? ram_rdata : '0);

	// board words 2..9 in order, word 2 at the bottom
	always_comb begin
		for (int w = 0; w < BOARD_WORDS; w++)
			board[w] = regs[REG_BOARD_LO + w];
	end

endmodule

`default_nettype wire

/* verilog/chess_move_pkg.sv */
`default_nettype none

package chess_move_pkg;

	// ======================================================================
	// lmg output fifo layout
	// ======================================================================

	localparam int ENTRIES_PER_WORD = 8;              // moves per fifo word
	localparam int ENTRY_BITS       = 19;             // one raw lmg move
	localparam int LMG_WORD_BITS    = 160;            // fifo word width
	localparam int COUNT_BITS       = 8;              // move counter, up to 255 moves
	localparam int ENTRY_IDX_BITS   = $clog2(ENTRIES_PER_WORD);
	localparam int LMG_PAD_BITS     = LMG_WORD_BITS - ENTRIES_PER_WORD * ENTRY_BITS;

	// raw entry as the lmg emits it, top bit first
	typedef struct packed {
		logic       invalid;    // slot carries no move
		logic [5:0] tag;        // piece / move kind tag from the lmg
		logic [2:0] from_file;
		logic [2:0] from_rank;
		logic [2:0] to_file;
		logic [2:0] to_rank;
	} lmg_entry_t;

	// entry k sits at bits 19k +: 19, top 8 bits carry nothing
	typedef struct packed {
		logic [LMG_PAD_BITS-1:0]           pad;
		lmg_entry_t [ENTRIES_PER_WORD-1:0] entry;
	} lmg_word_t;

	// stored move, rank and file swapped per square vs the lmg entry
	typedef struct packed {
		logic [5:0] tag;
		logic [2:0] from_rank;
		logic [2:0] from_file;
		logic [2:0] to_rank;
		logic [2:0] to_file;
	} move_t;

	// one write from the collector into the move ram
	typedef struct packed {
		logic                                 en;
		logic                                 is_count;  // goes to the count word
		logic [COUNT_BITS-1:0]                index;     // move slot, 0 = first move
		logic [chess_bus_pkg::DATA_WIDTH-1:0] data;
	} ram_wr_t;

	typedef enum logic [2:0] {
		IDLE, WAIT_DONE, POP, PREFETCH, SCAN, WRITE_COUNT, WRITE_TERM, FINISHED
	} collect_state_e;

endpackage

`default_nettype wire

/* verilog/chess_bus_pkg.sv */
`default_nettype none

package chess_bus_pkg;

	// ======================================================================
	// bus side and register window
	// ======================================================================

	localparam int DATA_WIDTH   = 32;                 // bus word, also the move ram word
	localparam int REG_WORDS    = 16;                 // window covers addresses 0..15
	localparam int REG_IDX_BITS = $clog2(REG_WORDS);  // low address bits that pick a register

	// register indices inside the window
	localparam int REG_CTRL     = 0;                  // control word
	localparam int REG_BOARD_LO = 2;                  // board bits 31:0
	localparam int REG_BOARD_HI = 9;                  // board bits 255:224
	localparam int BOARD_WORDS  = REG_BOARD_HI - REG_BOARD_LO + 1;

	// ======================================================================
	// move ram map, everything from 16 up is plain ram
	// ======================================================================

	localparam int ADDR_COUNT      = 16;              // number of moves in the list
	localparam int ADDR_FIRST_MOVE = 17;              // list grows upward from here

	// control word in register 0, top bit first
	typedef struct packed {
		logic [23:0] spare;     // free for software, just stored
		logic [2:0]  enp_file;  // file of the en-passant pawn
		logic        lcas;      // left side castle still allowed
		logic        rcas;      // right side castle still allowed
		logic        reserved;  // kept only to hold the bit position
		logic        done;      // hw sets this once the list is in ram
		logic        start;     // rising edge starts a new list
	} ctrl_word_t;

	// board image as words, element 0 is register 2
	// so the flat 256-bit view is {reg 9, ..., reg 2}
	typedef logic [BOARD_WORDS-1:0][DATA_WIDTH-1:0] board_t;

endpackage

`default_nettype wire
